// ==== common/capture_pkg.sv ====
package capture_pkg;

	////////////////////////////////////////
	// Widths with a meaning
	////////////////////////////////////////
	typedef logic [10:0] coord_t;       // Pixel or line counter
	typedef logic [11:0] wide_coord_t;  // Counter as stored in FIFO words
	typedef logic [15:0] blank_pos_t;   // Cycles since vde fell
	typedef logic [7:0]  colour_t;
	typedef logic [3:0]  nibble_t;      // One aux channel
	typedef logic [3:0]  ade_count_t;   // Aux periods per blanking
	typedef logic [7:0]  ascii_t;

	localparam int     ADE_PERIOD_LEN = 32; // Cycles in one aux period
	localparam int     REPORT_DIGITS  = 4;  // Hex digits per report
	localparam ascii_t ASCII_CR       = 8'h0d;
	localparam ascii_t ASCII_LF       = 8'h0a;

	////////////////////////////////////////
	// Records between the stages
	////////////////////////////////////////
	typedef struct packed {
		logic    hsync;
		logic    vsync;
		logic    vde;   // Video data period
		logic    ade;   // Aux data period
		colour_t red;
		colour_t green;
		colour_t blue;
		nibble_t aux0;
		nibble_t aux1;
		nibble_t aux2;
	} tmds_rx_t;

	// Decoded fields one cycle late, with the position counters alongside
	typedef struct packed {
		logic       hsync;
		logic       vsync;
		logic       vde;
		logic       ade;
		colour_t    red;
		colour_t    green;
		colour_t    blue;
		nibble_t    aux0;
		nibble_t    aux1;
		nibble_t    aux2;
		coord_t     hcount;
		coord_t     vcount;
		blank_pos_t pos;
		logic       started;  // Seen active video since reset
	} track_t;

	typedef struct packed {
		wide_coord_t vcount;
		wide_coord_t index;  // Pixel number inside the window
		colour_t     red;
		colour_t     green;
		colour_t     blue;
	} pix_word_t;

	typedef struct packed {
		blank_pos_t pos;
		nibble_t    aux2;
		nibble_t    aux1;
		logic       aux_bit;  // Bit 2 of aux0
	} aux_word_t;

	typedef enum logic [1:0] {
		IDLE,
		DIGITS,
		CR,
		LF
	} report_state_t;

endpackage

// ==== hw/line_tracker.sv ====
`timescale 1ns/10ps

module line_tracker (
	input  logic                  rx0_pclk,
	input  logic                  RSTBTN,
	input  capture_pkg::tmds_rx_t rx,
	output capture_pkg::track_t   trk
);
	import capture_pkg::*;

	tmds_rx_t   rx_q;        // Previous sample, also the delayed fields
	coord_t     hcount;
	coord_t     vcount;
	blank_pos_t pos;
	logic       started;
	logic       hsync_rise;
	logic       vsync_rise;

	// Edges are taken against the sample of the cycle before
	assign hsync_rise = rx.hsync & ~rx_q.hsync;
	assign vsync_rise = rx.vsync & ~rx_q.vsync;

	always_ff @(posedge rx0_pclk) begin
		rx_q <= rx;  // Levels and pixel data
	end

	////////////////////////////////////////
	// Position counters
	////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			hcount  <= '0;
			vcount  <= '0;
			pos     <= '0;
			started <= 1'b0;
		end else begin
			if (hsync_rise)
				hcount <= '0;
			else
				hcount <= hcount + 1'b1;

			if (vsync_rise)
				vcount <= '0;  // New frame
			else if (hsync_rise)
				vcount <= vcount + 1'b1;

			if (rx.vde)
				pos <= '0;
			else
				pos <= pos + 1'b1;  // Wraps in long blanking

			if (rx.vde)
				started <= 1'b1;  // Sticky until reset
		end
	end

	// One record, all fields from the same input cycle
	assign trk = '{
		hsync:   rx_q.hsync,
		vsync:   rx_q.vsync,
		vde:     rx_q.vde,
		ade:     rx_q.ade,
		red:     rx_q.red,
		green:   rx_q.green,
		blue:    rx_q.blue,
		aux0:    rx_q.aux0,
		aux1:    rx_q.aux1,
		aux2:    rx_q.aux2,
		hcount:  hcount,
		vcount:  vcount,
		pos:     pos,
		started: started
	};

endmodule

// ==== hw/pixel_packer.sv ====
`timescale 1ns/10ps

module pixel_packer #(
	parameter int WIN_START = 220,
	parameter int WIN_END   = 1420
) (
	input  logic                   rx0_pclk,
	input  logic                   RSTBTN,
	input  capture_pkg::track_t    trk,
	output capture_pkg::pix_word_t pix_word,
	output logic                   pix_wr
);
	import capture_pkg::*;

	logic        in_window;
	wide_coord_t index;

	////////////////////////////////////////
	// Window and index
	////////////////////////////////////////
	assign in_window = trk.vde
		&& (trk.hcount > coord_t'(WIN_START))
		&& (trk.hcount <= coord_t'(WIN_END));

	// First pixel after WIN_START gets index 0
	assign index = wide_coord_t'(trk.hcount) - wide_coord_t'(WIN_START + 1);

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN)
			pix_wr <= 1'b0;
		else
			pix_wr <= in_window;  // FIFO write strobe
	end

	always_ff @(posedge rx0_pclk) begin
		pix_word <= '{
			vcount: wide_coord_t'(trk.vcount),
			index:  index,
			red:    trk.red,
			green:  trk.green,
			blue:   trk.blue
		};
	end

endmodule

// ==== hw/aux_capture.sv ====
`timescale 1ns/10ps

module aux_capture (
	input  logic                    rx0_pclk,
	input  logic                    RSTBTN,
	input  capture_pkg::track_t     trk,
	output capture_pkg::aux_word_t  aux_word,
	output logic                    aux_wr,
	output capture_pkg::ade_count_t ade_num,
	output logic                    period_start,
	output capture_pkg::blank_pos_t start_pos
);
	import capture_pkg::*;

	localparam int PCNT_W = $clog2(ADE_PERIOD_LEN);

	logic              vde_q;
	logic [PCNT_W-1:0] period_cnt;  // Cycle inside current aux period
	ade_count_t        ade_run;     // Periods seen in this blanking
	logic              at_start;
	logic              vde_rise;

	assign at_start = trk.ade && (period_cnt == '0);
	assign vde_rise = trk.vde & ~vde_q & trk.started;  // End of blanking

	////////////////////////////////////////
	// Period counting
	////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			vde_q        <= 1'b0;
			period_cnt   <= '0;
			ade_run      <= '0;
			ade_num      <= '0;
			period_start <= 1'b0;
			aux_wr       <= 1'b0;
		end else begin
			vde_q        <= trk.vde;
			period_start <= at_start;
			aux_wr       <= trk.ade & trk.started;

			if (!trk.ade)
				period_cnt <= '0;
			else if (period_cnt == PCNT_W'(ADE_PERIOD_LEN - 1))
				period_cnt <= '0;
			else
				period_cnt <= period_cnt + 1'b1;

			// Latch and restart the count when video resumes
			if (vde_rise) begin
				ade_num <= ade_run;
				ade_run <= '0;
			end else if (at_start) begin
				ade_run <= ade_run + 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// Aux words
	////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		aux_word <= '{
			pos:     trk.pos,
			aux2:    trk.aux2,
			aux1:    trk.aux1,
			aux_bit: trk.aux0[2]
		};
		start_pos <= trk.pos;  // Blanking position of this cycle
	end

endmodule

// ==== hw/hex_reporter.sv ====
`timescale 1ns/10ps

module hex_reporter (
	input  logic                    rx0_pclk,
	input  logic                    RSTBTN,
	input  logic                    period_start,
	input  capture_pkg::blank_pos_t start_pos,
	output capture_pkg::ascii_t     report_byte,
	output logic                    report_wr
);
	import capture_pkg::*;

	localparam int CNT_W = $clog2(REPORT_DIGITS);
	localparam int TOP   = $bits(blank_pos_t) - 1;

	report_state_t    state;
	blank_pos_t       shift_q;    // Remaining digits, next one on top
	logic [CNT_W-1:0] digit_cnt;  // Digits already sent

	// Nibble to uppercase hex character
	function automatic ascii_t to_ascii(input nibble_t n);
		if (n < nibble_t'(10))
			return ascii_t'(n) + 8'h30;  // '0'..'9'
		return ascii_t'(n) + 8'h37;      // 'A'..'F'
	endfunction

	////////////////////////////////////////
	// Report FSM
	////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			state     <= IDLE;
			digit_cnt <= '0;
			report_wr <= 1'b0;
		end else begin
			report_wr <= (state != IDLE) || period_start;
			unique case (state)
				IDLE: begin
					if (period_start) begin  // Later starts wait for IDLE
						state     <= DIGITS;
						digit_cnt <= CNT_W'(1);
					end
				end
				DIGITS: begin
					if (digit_cnt == CNT_W'(REPORT_DIGITS - 1)) begin
						state     <= CR;
						digit_cnt <= '0;
					end else begin
						digit_cnt <= digit_cnt + 1'b1;
					end
				end
				CR: state <= LF;
				LF: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// Output byte and digit shifter
	////////////////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		unique case (state)
			IDLE: begin
				// First digit goes straight out of the captured position
				report_byte <= to_ascii(start_pos[TOP -: 4]);
				shift_q     <= start_pos << 4;
			end
			DIGITS: begin
				report_byte <= to_ascii(shift_q[TOP -: 4]);
				shift_q     <= shift_q << 4;
			end
			CR: report_byte <= ASCII_CR;
			LF: report_byte <= ASCII_LF;
			default: report_byte <= ASCII_LF;
		endcase
	end

endmodule

// ==== hw/capture_top.sv ====
`timescale 1ns/10ps

module capture_top #(
	parameter int WIN_START = 220,  // Last hcount before the window
	parameter int WIN_END   = 1420  // Last hcount inside the window
) (
	input  logic                   rx0_pclk,
	input  logic                   RSTBTN,
	input  capture_pkg::tmds_rx_t  rx,
	output capture_pkg::pix_word_t pix_word,
	output logic                   pix_wr,
	output capture_pkg::aux_word_t aux_word,
	output logic                   aux_wr,
	output capture_pkg::ade_count_t ade_num,
	output capture_pkg::ascii_t    report_byte,
	output logic                   report_wr
);
	import capture_pkg::*;

	track_t     trk;           // Aligned record from stage 1
	logic       period_start;  // One pulse per aux period
	blank_pos_t start_pos;

	////////////////////////////////////////
	// Stage 1, position tracking
	////////////////////////////////////////
	line_tracker u_line_tracker (
		.rx0_pclk (rx0_pclk),
		.RSTBTN   (RSTBTN),
		.rx       (rx),
		.trk      (trk)
	);

	////////////////////////////////////////
	// Stage 2, video and aux packing
	////////////////////////////////////////
	pixel_packer #(
		.WIN_START (WIN_START),
		.WIN_END   (WIN_END)
	) u_pixel_packer (
		.rx0_pclk (rx0_pclk),
		.RSTBTN   (RSTBTN),
		.trk      (trk),
		.pix_word (pix_word),
		.pix_wr   (pix_wr)
	);

	aux_capture u_aux_capture (
		.rx0_pclk     (rx0_pclk),
		.RSTBTN       (RSTBTN),
		.trk          (trk),
		.aux_word     (aux_word),
		.aux_wr       (aux_wr),
		.ade_num      (ade_num),
		.period_start (period_start),
		.start_pos    (start_pos)
	);

	////////////////////////////////////////
	// Stage 3, ASCII report
	////////////////////////////////////////
	hex_reporter u_hex_reporter (
		.rx0_pclk     (rx0_pclk),
		.RSTBTN       (RSTBTN),
		.period_start (period_start),
		.start_pos    (start_pos),
		.report_byte  (report_byte),
		.report_wr    (report_wr)
	);

endmodule

// ==== sim/capture_tb.sv ====
`timescale 1ns/10ps

module capture_tb;
	import capture_pkg::*;

	localparam int WIN_START   = 220;   // Defaults of capture_top
	localparam int WIN_END     = 1420;
	localparam int VSYNC_LINES = 2;     // Lines with vsync high at frame start
	localparam int MAX_FRAMES  = 32;

	// Expected stage-2 outputs for one driven sample
	typedef struct packed {
		logic        pix_wr;
		pix_word_t   pix;
		logic        aux_wr;
		aux_word_t   aux;
		ade_count_t  ade_num;
		logic        start;      // Aux period begins here
		blank_pos_t  start_pos;
		logic        vde_rise;
		logic        line_end;
		logic [11:0] words;      // Pixel words due on this line
		ade_count_t  ade_file;
	} expect_t;

	logic       rx0_pclk = 1'b0;
	logic       RSTBTN;
	tmds_rx_t   rx;
	pix_word_t  pix_word;
	logic       pix_wr;
	aux_word_t  aux_word;
	logic       aux_wr;
	ade_count_t ade_num;
	ascii_t     report_byte;
	logic       report_wr;

	expect_t exp_q[$];
	ascii_t  byte_q[$];
	int      limit_cycles = 0;
	int      line_words = 0;  // DUT pixel words on the current line

	int f_len[MAX_FRAMES];
	int f_sync[MAX_FRAMES];
	int f_act_s[MAX_FRAMES];
	int f_act_e[MAX_FRAMES];
	int f_lines[MAX_FRAMES];
	int f_aux[MAX_FRAMES];
	int f_words[MAX_FRAMES];
	int f_ade[MAX_FRAMES];

	// Reference model state
	logic       prev_hs = 1'b0;
	logic       prev_vs = 1'b0;
	coord_t     m_hcount = '0;
	coord_t     m_vcount = '0;
	blank_pos_t m_pos = '0;
	logic       m_started = 1'b0;
	logic       m_vde_q = 1'b0;
	int         m_pcnt = 0;
	ade_count_t m_run = '0;
	ade_count_t m_ade = '0;

	always #50 rx0_pclk = ~rx0_pclk;

	capture_top dut0 (
		.rx0_pclk    (rx0_pclk),
		.RSTBTN      (RSTBTN),
		.rx          (rx),
		.pix_word    (pix_word),
		.pix_wr      (pix_wr),
		.aux_word    (aux_word),
		.aux_wr      (aux_wr),
		.ade_num     (ade_num),
		.report_byte (report_byte),
		.report_wr   (report_wr)
	);

	////////////////////////////////////////
	// Failure and compare tasks
	////////////////////////////////////////
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_strobe(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_run($sformatf("[ERROR] %0t %s expected %b got %b", $time, name, exp, act));
	endtask

	task automatic check_pix(input string name, input pix_word_t exp, input pix_word_t act);
		if (act !== exp)
			stop_run($sformatf("[ERROR] %0t %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_aux(input string name, input aux_word_t exp, input aux_word_t act);
		if (act !== exp)
			stop_run($sformatf("[ERROR] %0t %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_count(input string name, input ade_count_t exp, input ade_count_t act);
		if (act !== exp)
			stop_run($sformatf("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act));
	endtask

	task automatic check_byte(input string name, input ascii_t exp, input ascii_t act);
		if (act !== exp)
			stop_run($sformatf("[ERROR] %0t %s expected %h got %h", $time, name, exp, act));
	endtask

	task automatic check_total(input string name, input int exp, input int act);
		if (act != exp)
			stop_run($sformatf("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act));
	endtask

	function automatic ascii_t hex_char(input nibble_t n);
		if (n > 4'd9)
			return "A" + ascii_t'(n - 4'd10);
		return "0" + ascii_t'(n);
	endfunction

	////////////////////////////////////////
	// Reference model, one call per sample
	////////////////////////////////////////
	task automatic model_sample(input tmds_rx_t s, input logic line_end,
			input logic [11:0] words, input ade_count_t ade_file);
		expect_t e;
		logic    hs_rise;
		logic    vs_rise;
		hs_rise = s.hsync & ~prev_hs;
		vs_rise = s.vsync & ~prev_vs;
		prev_hs = s.hsync;
		prev_vs = s.vsync;
		m_hcount = hs_rise ? coord_t'(0) : coord_t'(m_hcount + 1'b1);
		if (vs_rise)
			m_vcount = '0;
		else if (hs_rise)
			m_vcount = m_vcount + 1'b1;
		m_pos = s.vde ? blank_pos_t'(0) : blank_pos_t'(m_pos + 1'b1);
		m_started = m_started | s.vde;
		e = '0;
		e.pix_wr = s.vde && m_hcount > WIN_START && m_hcount <= WIN_END;
		e.pix = '{wide_coord_t'(m_vcount), wide_coord_t'(m_hcount - (WIN_START + 1)),
			s.red, s.green, s.blue};
		e.aux_wr = s.ade && m_started;
		e.aux = '{m_pos, s.aux2, s.aux1, s.aux0[2]};
		e.start = s.ade && m_pcnt == 0;
		e.start_pos = m_pos;
		e.vde_rise = s.vde && !m_vde_q && m_started;
		m_vde_q = s.vde;
		m_pcnt = s.ade ? (m_pcnt + 1) % ADE_PERIOD_LEN : 0;
		if (e.vde_rise) begin
			m_ade = m_run;  // Periods of the blanking just ended
			m_run = '0;
		end else if (e.start) begin
			m_run = m_run + 1'b1;
		end
		e.ade_num = m_ade;
		e.line_end = line_end;
		e.words = words;
		e.ade_file = ade_file;
		exp_q.push_back(e);
	endtask

	task automatic check_cycle();
		expect_t e;
		// Report bytes first, a start popped below is due from the next cycle
		if (byte_q.size() != 0) begin
			check_strobe("report_wr", 1'b1, report_wr);
			check_byte("report_byte", byte_q.pop_front(), report_byte);
		end else begin
			check_strobe("report_wr", 1'b0, report_wr);
		end
		if (exp_q.size() < 3) begin  // Pipeline still holds reset values
			check_strobe("pix_wr", 1'b0, pix_wr);
			check_strobe("aux_wr", 1'b0, aux_wr);
			check_count("ade_num", '0, ade_num);
			return;
		end
		e = exp_q.pop_front();
		check_strobe("pix_wr", e.pix_wr, pix_wr);
		if (e.pix_wr)
			check_pix("pix_word", e.pix, pix_word);
		check_strobe("aux_wr", e.aux_wr, aux_wr);
		if (e.aux_wr)
			check_aux("aux_word", e.aux, aux_word);
		check_count("ade_num", e.ade_num, ade_num);
		if (e.vde_rise)
			check_count("ade_num per blanking", e.ade_file, ade_num);
		line_words += pix_wr;
		if (e.line_end) begin
			check_total("pixel words per line", e.words, line_words);
			line_words = 0;
		end
		if (e.start && byte_q.size() == 0) begin  // Busy reporter drops the start
			for (int i = REPORT_DIGITS - 1; i >= 0; i--)
				byte_q.push_back(hex_char(e.start_pos[4*i +: 4]));
			byte_q.push_back(ASCII_CR);
			byte_q.push_back(ASCII_LF);
		end
	endtask

	task automatic drive_sample(input tmds_rx_t s, input logic line_end,
			input logic [11:0] words, input ade_count_t ade_file);
		@(posedge rx0_pclk);
		RSTBTN <= 1'b0;  // Third reset edge carries the first sample
		rx     <= s;
		model_sample(s, line_end, words, ade_file);
		@(negedge rx0_pclk);
		check_cycle();
	endtask

	////////////////////////////////////////
	// Scenario
	////////////////////////////////////////
	initial begin
		int               fd;
		int               rc;
		int               n_frames;
		logic [8*256-1:0] text_line;
		tmds_rx_t         s;
		logic             active;
		void'($urandom(32'h02e5_bf98));
		rx     <= '0;
		RSTBTN <= 1'b1;
		n_frames = 0;
		fd = $fopen("sim/capture_input.txt", "r");
		if (fd == 0)
			stop_run("could not open sim/capture_input.txt");
		while (!$feof(fd) && n_frames < MAX_FRAMES) begin
			text_line = '0;
			rc = $fgets(text_line, fd);
			rc = $sscanf(text_line, "%d %d %d %d %d %d %d %d", f_len[n_frames],
				f_sync[n_frames], f_act_s[n_frames], f_act_e[n_frames],
				f_lines[n_frames], f_aux[n_frames], f_words[n_frames], f_ade[n_frames]);
			if (rc == 8) begin
				limit_cycles += 2 * f_len[n_frames] * f_lines[n_frames];
				n_frames++;
			end else if (rc > 0) begin
				stop_run("a frame line in sim/capture_input.txt has too few numbers");
			end
		end
		$fclose(fd);
		if (n_frames == 0)
			stop_run("sim/capture_input.txt holds no frames");
		repeat (2) @(posedge rx0_pclk);
		for (int f = 0; f < n_frames; f++) begin
			for (int ln = 0; ln < f_lines[f]; ln++) begin
				active = ln >= VSYNC_LINES;
				for (int h = 0; h < f_len[f]; h++) begin
					s.hsync = h < f_sync[f];
					s.vsync = ln < VSYNC_LINES;
					s.vde = active && h >= f_act_s[f] && h < f_act_e[f];
					s.ade = active && h >= f_sync[f] + 2
						&& h < f_sync[f] + 2 + ADE_PERIOD_LEN * f_aux[f];  // Back porch
					{s.red, s.green, s.blue} = 24'($urandom);
					{s.aux0, s.aux1, s.aux2} = 12'($urandom);
					drive_sample(s, h == f_len[f] - 1, active ? 12'(f_words[f]) : 12'd0,
						ade_count_t'(f_ade[f]));
				end
			end
		end
		repeat (16)
			drive_sample('0, 1'b0, 12'd0, '0);  // Flush pipeline and reports
		if (byte_q.size() == 0 && line_words == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			stop_run("report bytes or pixel words were still pending at the end");
		end
	end

	// Watchdog, twice the frame cycles from the scenario
	initial begin
		wait (limit_cycles != 0);
		repeat (limit_cycles) @(posedge rx0_pclk);
		stop_run("timeout, the run did not finish within the watchdog limit");
	end

endmodule

// ==== sim/capture_input.txt ====
# line_len sync_w act_start act_end lines aux_periods words_per_line ade_num
# Lines 0 and 1 of each frame carry vsync, video and aux come on the lines after
1650 40 260 1540 5 2 1161 2
800 96 144 784 5 1 563 1
1000 20 200 900 4 4 679 4
1600 10 230 1500 6 3 1191 3
500 30 100 400 4 0 179 0
1500 50 180 1480 5 3 1200 3

// ==== src.f ====
common/capture_pkg.sv
hw/line_tracker.sv
hw/pixel_packer.sv
hw/aux_capture.sv
hw/hex_reporter.sv
hw/capture_top.sv
sim/capture_tb.sv

// ==== Bender.yml ====
package:
  name: dvi_capture

sources:
  - common/capture_pkg.sv
  - hw/line_tracker.sv
  - hw/pixel_packer.sv
  - hw/aux_capture.sv
  - hw/hex_reporter.sv
  - hw/capture_top.sv
  - target: simulation
    files:
      - sim/capture_tb.sv
